/* common/mips_trace_pkg.sv */
package mips_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Primary opcodes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_COP0    = 6'b010000;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL     = 6'b000000;
    localparam logic [5:0] FN_SRL     = 6'b000010;
    localparam logic [5:0] FN_SRA     = 6'b000011;
    localparam logic [5:0] FN_SLLV    = 6'b000100;
    localparam logic [5:0] FN_SRLV    = 6'b000110;
    localparam logic [5:0] FN_SRAV    = 6'b000111;
    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001;
    localparam logic [5:0] FN_SYSCALL = 6'b001100;
    localparam logic [5:0] FN_BREAK   = 6'b001101;
    localparam logic [5:0] FN_MFHI    = 6'b010000;
    localparam logic [5:0] FN_MTHI    = 6'b010001;
    localparam logic [5:0] FN_MFLO    = 6'b010010;
    localparam logic [5:0] FN_MTLO    = 6'b010011;
    localparam logic [5:0] FN_MULT    = 6'b011000;
    localparam logic [5:0] FN_MULTU   = 6'b011001;
    localparam logic [5:0] FN_DIV     = 6'b011010;
    localparam logic [5:0] FN_DIVU    = 6'b011011;
    localparam logic [5:0] FN_ADD     = 6'b100000;
    localparam logic [5:0] FN_ADDU    = 6'b100001;
    localparam logic [5:0] FN_SUB     = 6'b100010;
    localparam logic [5:0] FN_SUBU    = 6'b100011;
    localparam logic [5:0] FN_AND     = 6'b100100;
    localparam logic [5:0] FN_OR      = 6'b100101;
    localparam logic [5:0] FN_XOR     = 6'b100110;
    localparam logic [5:0] FN_NOR     = 6'b100111;
    localparam logic [5:0] FN_SLT     = 6'b101010;
    localparam logic [5:0] FN_SLTU    = 6'b101011;

    // REGIMM branches, selected by rt
    localparam logic [4:0] RT_BLTZ    = 5'b00000;
    localparam logic [4:0] RT_BGEZ    = 5'b00001;
    localparam logic [4:0] RT_BLTZAL  = 5'b10000;
    localparam logic [4:0] RT_BGEZAL  = 5'b10001;

    // COP0 moves by rs, ERET only as the full word
    localparam logic [4:0]  RS_MF     = 5'b00000;
    localparam logic [4:0]  RS_MT     = 5'b00100;
    localparam logic [31:0] ERET_WORD = 32'h4200_0018;

    ////////////////////////////////////////////////////////////////////////////
    // Trace entry sizes and class codes
    ////////////////////////////////////////////////////////////////////////////
    // Six ASCII characters, right-aligned, NUL padded on the left
    localparam int MNEM_W  = 48;
    localparam int CLS_W   = 3;
    localparam int PC_W    = 32;
    localparam int ENTRY_W = PC_W + MNEM_W + CLS_W;

    localparam logic [CLS_W-1:0] CLS_ALU   = 3'd0;
    localparam logic [CLS_W-1:0] CLS_SHIFT = 3'd1;
    localparam logic [CLS_W-1:0] CLS_HILO  = 3'd2;
    localparam logic [CLS_W-1:0] CLS_FLOW  = 3'd3;
    localparam logic [CLS_W-1:0] CLS_MEM   = 3'd4;
    localparam logic [CLS_W-1:0] CLS_SYS   = 3'd5;
    localparam logic [CLS_W-1:0] CLS_NOP   = 3'd6;
    localparam logic [CLS_W-1:0] CLS_BAD   = 3'd7;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // Register map
    localparam logic [1:0] REG_CTRL     = 2'd0;
    localparam logic [1:0] REG_CAPTURED = 2'd1;
    localparam logic [1:0] REG_DROPPED  = 2'd2;
    localparam logic [1:0] REG_LEVEL    = 2'd3;

    // Same 32 bits seen as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

/* design/mnemonic/inst_ascii_decoder.sv */
module inst_ascii_decoder
    import mips_trace_pkg::*;
(
    input  instr_t            instr,
    output logic [MNEM_W-1:0] mnem
);

    always_comb begin
        mnem = "N-R";
        if (instr == '0) begin
            // All-zero word would otherwise read as SLL
            mnem = "NOP";
        end else begin
            case (instr.j.op)
                OP_SPECIAL: begin
                    case (instr.r.funct)
                        // Logic
                        FN_AND:     mnem = "AND";
                        FN_OR:      mnem = "OR";
                        FN_XOR:     mnem = "XOR";
                        FN_NOR:     mnem = "NOR";
                        // Shifts
                        FN_SLL:     mnem = "SLL";
                        FN_SRL:     mnem = "SRL";
                        FN_SRA:     mnem = "SRA";
                        FN_SLLV:    mnem = "SLLV";
                        FN_SRLV:    mnem = "SRLV";
                        FN_SRAV:    mnem = "SRAV";
                        // HI/LO moves
                        FN_MFHI:    mnem = "MFHI";
                        FN_MTHI:    mnem = "MTHI";
                        FN_MFLO:    mnem = "MFLO";
                        FN_MTLO:    mnem = "MTLO";
                        // Arithmetic
                        FN_ADD:     mnem = "ADD";
                        FN_ADDU:    mnem = "ADDU";
                        FN_SUB:     mnem = "SUB";
                        FN_SUBU:    mnem = "SUBU";
                        FN_SLT:     mnem = "SLT";
                        FN_SLTU:    mnem = "SLTU";
                        FN_MULT:    mnem = "MULT";
                        FN_MULTU:   mnem = "MULTU";
                        FN_DIV:     mnem = "DIV";
                        FN_DIVU:    mnem = "DIVU";
                        // Register jumps
                        FN_JR:      mnem = "JR";
                        FN_JALR:    mnem = "JALR";
                        // Traps keep their short names
                        FN_SYSCALL: mnem = "SYSC";
                        FN_BREAK:   mnem = "BRE";
                        default:    mnem = "N-R";
                    endcase
                end
                OP_REGIMM: begin
                    case (instr.i.rt)
                        RT_BGEZ:   mnem = "BGEZ";
                        RT_BGEZAL: mnem = "BGEZAL";
                        RT_BLTZ:   mnem = "BLTZ";
                        RT_BLTZAL: mnem = "BLTZAL";
                        default:   mnem = "N-R";
                    endcase
                end
                OP_COP0: begin
                    if (instr == ERET_WORD) begin
                        mnem = "ERET";
                    end else if (instr.r.rs == RS_MT) begin
                        mnem = "MTOC0";
                    end else if (instr.r.rs == RS_MF) begin
                        mnem = "MFC0";
                    end else begin
                        mnem = "N-R";
                    end
                end
                // Immediate ALU group
                OP_ANDI:  mnem = "ANDI";
                OP_ORI:   mnem = "ORI";
                OP_XORI:  mnem = "XORI";
                OP_LUI:   mnem = "LUI";
                OP_ADDI:  mnem = "ADDI";
                OP_ADDIU: mnem = "ADDIU";
                OP_SLTI:  mnem = "SLTI";
                OP_SLTIU: mnem = "SLTIU";
                // Jumps and branches
                OP_J:     mnem = "J";
                OP_JAL:   mnem = "JAL";
                OP_BEQ:   mnem = "BEQ";
                OP_BNE:   mnem = "BNE";
                OP_BLEZ:  mnem = "BLEZ";
                OP_BGTZ:  mnem = "BGTZ";
                // Loads and stores
                OP_LB:    mnem = "LB";
                OP_LBU:   mnem = "LBU";
                OP_LH:    mnem = "LH";
                OP_LHU:   mnem = "LHU";
                OP_LW:    mnem = "LW";
                OP_SB:    mnem = "SB";
                OP_SH:    mnem = "SH";
                OP_SW:    mnem = "SW";
                default:  mnem = "N-R";
            endcase
        end
    end

endmodule

/* design/mnemonic/instr_classifier.sv */
module instr_classifier
    import mips_trace_pkg::*;
(
    input  instr_t           instr,
    output logic [CLS_W-1:0] cls
);

    always_comb begin
        cls = CLS_BAD;
        if (instr == '0) begin
            cls = CLS_NOP;
        end else begin
            case (instr.j.op)
                OP_SPECIAL: begin
                    case (instr.r.funct)
                        FN_AND, FN_OR, FN_XOR, FN_NOR,
                        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                        FN_SLT, FN_SLTU:                      cls = CLS_ALU;
                        FN_SLL, FN_SRL, FN_SRA,
                        FN_SLLV, FN_SRLV, FN_SRAV:            cls = CLS_SHIFT;
                        FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO,
                        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:   cls = CLS_HILO;
                        FN_JR, FN_JALR:                       cls = CLS_FLOW;
                        FN_SYSCALL, FN_BREAK:                 cls = CLS_SYS;
                        default:                              cls = CLS_BAD;
                    endcase
                end
                OP_REGIMM: begin
                    case (instr.i.rt)
                        RT_BGEZ, RT_BGEZAL,
                        RT_BLTZ, RT_BLTZAL: cls = CLS_FLOW;
                        default:            cls = CLS_BAD;
                    endcase
                end
                OP_COP0: begin
                    if (instr == ERET_WORD || instr.r.rs == RS_MF || instr.r.rs == RS_MT) begin
                        cls = CLS_SYS;
                    end else begin
                        cls = CLS_BAD;
                    end
                end
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: cls = CLS_ALU;
                OP_J, OP_JAL, OP_BEQ, OP_BNE,
                OP_BLEZ, OP_BGTZ:                     cls = CLS_FLOW;
                OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
                OP_SB, OP_SH, OP_SW:                  cls = CLS_MEM;
                default:                              cls = CLS_BAD;
            endcase
        end
    end

endmodule

/* design/trace_cfg_regs.sv */
module trace_cfg_regs
    import mips_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  logic [1:0]         cfg_addr,
    input  logic [31:0]        cfg_wdata,
    output logic [31:0]        cfg_rdata,
    input  logic               retire_valid,
    input  logic [CLS_W-1:0]   cls,
    input  logic               fifo_full,
    input  logic [FIFO_AW:0]   fifo_level,
    output logic               capture_push
);

    logic                    enable;
    logic [(1<<CLS_W)-1:0]   class_mask;
    logic [31:0]             captured_cnt;
    logic [31:0]             dropped_cnt;
    logic                    hit;
    logic                    drop;

    // Filter, then split on FIFO space
    assign hit          = retire_valid & enable & class_mask[cls];
    assign capture_push = hit & ~fifo_full;
    assign drop         = hit & fifo_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable       <= 1'b0;
            class_mask   <= '0;
            captured_cnt <= '0;
            dropped_cnt  <= '0;
        end else begin
            if (cfg_we && cfg_addr == REG_CTRL) begin
                enable     <= cfg_wdata[0];
                class_mask <= cfg_wdata[15:8];
            end
            // Counters stick at all ones
            if (capture_push && captured_cnt != '1) begin
                captured_cnt <= captured_cnt + 32'd1;
            end
            if (drop && dropped_cnt != '1) begin
                dropped_cnt <= dropped_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CTRL:     cfg_rdata = {16'd0, class_mask, 7'd0, enable};
            REG_CAPTURED: cfg_rdata = captured_cnt;
            REG_DROPPED:  cfg_rdata = dropped_cnt;
            default:      cfg_rdata = 32'(fifo_level);
        endcase
    end

endmodule

/* design/trace_fifo.sv */
module trace_fifo
    import mips_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  logic [ENTRY_W-1:0] push_data,
    input  logic               pop,
    output logic [ENTRY_W-1:0] head_data,
    output logic               empty,
    output logic               full,
    output logic [FIFO_AW:0]   level
);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_pop;

    // Push arrives already qualified by the config block
    assign do_pop    = pop & ~empty;
    assign empty     = (level == '0);
    assign full      = (level == (FIFO_AW+1)'(FIFO_DEPTH));
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* design/instr_trace_top.sv */
module instr_trace_top
    import mips_trace_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Retire side
    input  logic              retire_valid,
    input  logic [PC_W-1:0]   retire_pc,
    input  logic [31:0]       retire_instr,
    // Host drain side
    input  logic              trace_pop,
    output logic              trace_empty,
    output logic [PC_W-1:0]   trace_pc,
    output logic [MNEM_W-1:0] trace_mnem,
    output logic [CLS_W-1:0]  trace_cls,
    // Configuration side
    input  logic              cfg_we,
    input  logic [1:0]        cfg_addr,
    input  logic [31:0]       cfg_wdata,
    output logic [31:0]       cfg_rdata
);

    logic [MNEM_W-1:0]  mnem;
    logic [CLS_W-1:0]   cls;
    logic               capture_push;
    logic               fifo_full;
    logic [FIFO_AW:0]   fifo_level;
    logic [ENTRY_W-1:0] push_entry;
    logic [ENTRY_W-1:0] head_entry;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////
    inst_ascii_decoder u_decoder (
        .instr (instr_t'(retire_instr)),
        .mnem  (mnem)
    );

    instr_classifier u_classifier (
        .instr (instr_t'(retire_instr)),
        .cls   (cls)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Filter and buffer
    ////////////////////////////////////////////////////////////////////////////
    trace_cfg_regs u_cfg (
        .clk          (clk),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .retire_valid (retire_valid),
        .cls          (cls),
        .fifo_full    (fifo_full),
        .fifo_level   (fifo_level),
        .capture_push (capture_push)
    );

    // Entry layout is pc, mnemonic, class from MSB down
    assign push_entry = {retire_pc, mnem, cls};

    trace_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (capture_push),
        .push_data (push_entry),
        .pop       (trace_pop),
        .head_data (head_entry),
        .empty     (trace_empty),
        .full      (fifo_full),
        .level     (fifo_level)
    );

    assign trace_pc   = head_entry[ENTRY_W-1 -: PC_W];
    assign trace_mnem = head_entry[CLS_W +: MNEM_W];
    assign trace_cls  = head_entry[CLS_W-1:0];

endmodule

/* tb/trace_fifo_checker.sv */
module trace_fifo_checker
    import mips_trace_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             pop,
    input logic             empty,
    input logic             full,
    input logic [FIFO_AW:0] level
);

    // Occupancy bound
    level_bound: assert property (@(posedge clk) disable iff (rst)
        level <= (FIFO_AW+1)'(FIFO_DEPTH))
        else $error("FIFO level above its depth");

    flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(empty && full))
        else $error("FIFO empty and full at the same time");

    // Without a pop a full buffer keeps its level
    full_push_hold: assert property (@(posedge clk) disable iff (rst)
        (full && !pop) |=> $stable(level))
        else $error("FIFO level moved while full with no pop");

    reset_empty: assert property (@(posedge clk) rst |=> empty)
        else $error("FIFO not empty after reset");

endmodule

bind trace_fifo trace_fifo_checker u_fifo_checker (
    .clk   (clk),
    .rst   (rst),
    .pop   (pop),
    .empty (empty),
    .full  (full),
    .level (level)
);

/* tb/instr_trace_tb.sv */
module instr_trace_tb
    import mips_trace_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NROWS      = 17;
    localparam int TIMEOUT    = (NROWS * 4 + 64) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              retire_valid;
    logic [PC_W-1:0]   retire_pc;
    logic [31:0]       retire_instr;
    logic              trace_pop;
    logic              trace_empty;
    logic [PC_W-1:0]   trace_pc;
    logic [MNEM_W-1:0] trace_mnem;
    logic [CLS_W-1:0]  trace_cls;
    logic              cfg_we;
    logic [1:0]        cfg_addr;
    logic [31:0]       cfg_wdata;
    logic [31:0]       cfg_rdata;

    // Stimulus table, one row per instruction
    logic [31:0]       tbl_instr [NROWS];
    logic [PC_W-1:0]   tbl_pc    [NROWS];
    logic [MNEM_W-1:0] tbl_mnem  [NROWS];
    logic [CLS_W-1:0]  tbl_cls   [NROWS];

    // Reference model, FIFO holds row indices
    int          model_q[$];
    logic        model_en;
    logic [7:0]  model_mask;
    logic [31:0] model_captured;
    logic [31:0] model_dropped;

    instr_trace_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .trace_pop    (trace_pop),
        .trace_empty  (trace_empty),
        .trace_pc     (trace_pc),
        .trace_mnem   (trace_mnem),
        .trace_cls    (trace_cls),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic set_row(input int idx, input logic [31:0] instr,
                           input logic [MNEM_W-1:0] mnem, input logic [CLS_W-1:0] cls);
        tbl_instr[idx] = instr;
        tbl_pc[idx]    = 32'h0040_0000 + 32'(idx * 4);
        tbl_mnem[idx]  = mnem;
        tbl_cls[idx]   = cls;
    endtask

    task automatic load_table();
        set_row(0,  32'h0022_1824, "AND",    CLS_ALU);
        set_row(1,  32'h0001_1100, "SLL",    CLS_SHIFT);
        set_row(2,  32'h0022_0019, "MULTU",  CLS_HILO);
        set_row(3,  32'h0080_F809, "JALR",   CLS_FLOW);
        set_row(4,  32'h0000_000C, "SYSC",   CLS_SYS);
        set_row(5,  32'h2402_0005, "ADDIU",  CLS_ALU);
        set_row(6,  32'h3C01_1234, "LUI",    CLS_ALU);
        set_row(7,  32'h1022_0004, "BEQ",    CLS_FLOW);
        set_row(8,  32'h0471_0008, "BGEZAL", CLS_FLOW);
        set_row(9,  32'h8FA2_0004, "LW",     CLS_MEM);
        set_row(10, 32'hAFA2_0008, "SW",     CLS_MEM);
        set_row(11, 32'h4002_6000, "MFC0",   CLS_SYS);
        set_row(12, 32'h4082_7000, "MTOC0",  CLS_SYS);
        set_row(13, 32'h4200_0018, "ERET",   CLS_SYS);
        set_row(14, 32'h0000_0000, "NOP",    CLS_NOP);
        // Unknown funct, then unknown opcode
        set_row(15, 32'h0022_1801, "N-R",    CLS_BAD);
        set_row(16, 32'hFC00_0000, "N-R",    CLS_BAD);
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic [7:0] mask);
        return {16'd0, mask, 7'd0, en};
    endfunction

    task automatic check_state();
        check_val("trace_empty", 64'(model_q.size() == 0), 64'(trace_empty));
        if (model_q.size() != 0) begin
            check_val("trace_pc", 64'(tbl_pc[model_q[0]]), 64'(trace_pc));
            check_val("trace_mnem", 64'(tbl_mnem[model_q[0]]), 64'(trace_mnem));
            check_val("trace_cls", 64'(tbl_cls[model_q[0]]), 64'(trace_cls));
        end
    endtask

    // Readback settles within the cycle, next drive on the falling edge
    task automatic check_reg(input logic [1:0] addr, input logic [31:0] expected,
                             input string name);
        cfg_addr = addr;
        #1;
        check_val(name, 64'(expected), 64'(cfg_rdata));
        @(negedge clk);
    endtask

    // Strobes last one cycle, outputs checked at the next falling edge
    task automatic end_cycle();
        @(negedge clk);
        retire_valid = 1'b0;
        trace_pop    = 1'b0;
        cfg_we       = 1'b0;
        check_state();
    endtask

    task automatic retire_cycle(input logic valid, input int row, input logic pop);
        logic hit;
        logic was_empty;
        logic was_full;
        retire_valid = valid;
        retire_pc    = tbl_pc[row];
        retire_instr = tbl_instr[row];
        trace_pop    = pop;
        hit       = valid && model_en && model_mask[tbl_cls[row]];
        was_empty = (model_q.size() == 0);
        was_full  = (model_q.size() == FIFO_DEPTH);
        if (pop && !was_empty) begin
            void'(model_q.pop_front());
        end
        if (hit && !was_full) begin
            model_q.push_back(row);
            model_captured = model_captured + 32'd1;
        end
        if (hit && was_full) begin
            model_dropped = model_dropped + 32'd1;
        end
        end_cycle();
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        if (addr == REG_CTRL) begin
            model_en   = data[0];
            model_mask = data[15:8];
        end
        end_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          n_sel;
        logic [31:0] cap_before;
        load_table();
        rst          = 1'b1;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_instr = '0;
        trace_pop    = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = REG_CTRL;
        cfg_wdata    = '0;
        model_en       = 1'b0;
        model_mask     = '0;
        model_captured = '0;
        model_dropped  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values, then retire while disabled
        check_state();
        check_reg(REG_CTRL, 32'd0, "REG_CTRL");
        check_reg(REG_CAPTURED, 32'd0, "REG_CAPTURED");
        check_reg(REG_DROPPED, 32'd0, "REG_DROPPED");
        check_reg(REG_LEVEL, 32'd0, "REG_LEVEL");
        // Mask fully open so only the enable bit holds entries back
        cfg_write(REG_CTRL, ctrl_word(1'b0, 8'hFF));
        for (int i = 0; i < 6; i++) begin
            retire_cycle(1'b1, i, 1'b0);
        end
        check_reg(REG_CAPTURED, 32'd0, "REG_CAPTURED");
        check_reg(REG_LEVEL, 32'd0, "REG_LEVEL");

        // Every row through an open filter
        cfg_write(REG_CTRL, ctrl_word(1'b1, 8'hFF));
        check_reg(REG_CTRL, ctrl_word(1'b1, 8'hFF), "REG_CTRL");
        for (int i = 0; i < NROWS; i++) begin
            retire_cycle(1'b1, i, 1'b0);
            retire_cycle(1'b0, 0, 1'b1);
        end
        check_reg(REG_CAPTURED, model_captured, "REG_CAPTURED");

        // Only branches, jumps, loads and stores
        cap_before = model_captured;
        n_sel      = 0;
        cfg_write(REG_CTRL, ctrl_word(1'b1, 8'(1 << CLS_MEM) | 8'(1 << CLS_FLOW)));
        for (int i = 0; i < NROWS; i++) begin
            retire_cycle(1'b1, i, 1'b0);
            if (tbl_cls[i] == CLS_MEM || tbl_cls[i] == CLS_FLOW) begin
                n_sel = n_sel + 1;
            end
        end
        check_reg(REG_LEVEL, 32'(n_sel), "REG_LEVEL");
        while (model_q.size() != 0) begin
            retire_cycle(1'b0, 0, 1'b1);
        end
        check_reg(REG_CAPTURED, cap_before + 32'(n_sel), "REG_CAPTURED");

        // Overflow with no pops
        cfg_write(REG_CTRL, ctrl_word(1'b1, 8'hFF));
        for (int i = 0; i < 11; i++) begin
            retire_cycle(1'b1, i, 1'b0);
        end
        check_reg(REG_LEVEL, 32'd8, "REG_LEVEL");
        check_reg(REG_DROPPED, 32'd3, "REG_DROPPED");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            retire_cycle(1'b0, 0, 1'b1);
        end
        check_reg(REG_LEVEL, 32'd0, "REG_LEVEL");

        // Pop and retire in the same cycle
        retire_cycle(1'b1, 0, 1'b0);
        retire_cycle(1'b1, 1, 1'b0);
        check_reg(REG_LEVEL, 32'd2, "REG_LEVEL");
        retire_cycle(1'b1, 2, 1'b1);
        check_reg(REG_LEVEL, 32'd2, "REG_LEVEL");
        retire_cycle(1'b0, 0, 1'b1);
        retire_cycle(1'b0, 0, 1'b1);

        // Pop while empty, write to a read-only counter
        retire_cycle(1'b0, 0, 1'b1);
        check_reg(REG_LEVEL, 32'd0, "REG_LEVEL");
        cfg_write(REG_CAPTURED, 32'h1234_5600);
        check_reg(REG_CAPTURED, model_captured, "REG_CAPTURED");
        check_reg(REG_DROPPED, model_dropped, "REG_DROPPED");
        check_reg(REG_CTRL, ctrl_word(1'b1, 8'hFF), "REG_CTRL");

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog.f */
common/mips_trace_pkg.sv
design/mnemonic/inst_ascii_decoder.sv
design/mnemonic/instr_classifier.sv
design/trace_cfg_regs.sv
design/trace_fifo.sv
design/instr_trace_top.sv
tb/trace_fifo_checker.sv
tb/instr_trace_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= instr_trace_tb
RTL_TOP   ?= instr_trace_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
